// File: source/ExecTypesPkg.sv
package ExecTypesPkg;

	//////////////////////
	// Field widths
	//////////////////////
	localparam int DataWidth    = 32;
	localparam int IssueNoWidth = 6;	// Wraps, age taken modulo 64
	localparam int RegIdxWidth  = 5;
	localparam int AddrWidth    = 16;	// Bit 0 picks the bank

	//////////////////////
	// Command fields
	//////////////////////
	typedef logic [DataWidth-1:0]    dataT;
	typedef logic [IssueNoWidth-1:0] issueNoT;
	typedef logic [RegIdxWidth-1:0]  regIdxT;
	typedef logic [AddrWidth-1:0]    addrT;

	// Command opcodes, codes 6 and 7 unused
	typedef enum logic [2:0] {
		OpMulAdd = 3'd0,	// a*b+c
		OpMul    = 3'd1,	// a*b, addend forced to 0
		OpAdd    = 3'd2,	// a+c, multiplier forced to 1
		OpMove   = 3'd3,	// Register move through ring buffer
		OpLoad   = 3'd4,
		OpStore  = 3'd5
	} opT;

endpackage

// File: source/ExecConfigPkg.sv
package ExecConfigPkg;

	localparam int MulAddDepth  = 4;	// MAU stages, product in 1, addend in 2
	localparam int MoveDepth    = 8;	// Move ring entries
	localparam int NumBanks     = 2;	// Even and odd load/store units
	localparam int NumWbSources = NumBanks + 2;	// MAU, banks, move buffer

	// Half the issue number range so age compares stay unambiguous
	localparam int MaxInFlight  = 32;

endpackage

// File: source/ExecControl.sv
module ExecControl (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    req,
	input  ExecTypesPkg::issueNoT   curIssueNo,
	input  ExecTypesPkg::opT        op,
	input  ExecTypesPkg::regIdxT    dst,
	input  ExecTypesPkg::issueNoT   issueNo,
	input  ExecTypesPkg::dataT      srcA,
	input  ExecTypesPkg::dataT      srcB,
	input  ExecTypesPkg::dataT      srcC,
	output logic                    mauStart,
	output ExecTypesPkg::dataT      mauA,
	output ExecTypesPkg::dataT      mauB,
	output ExecTypesPkg::dataT      mauC,
	output ExecTypesPkg::regIdxT    mauTagDst,
	output ExecTypesPkg::issueNoT   mauTagIssueNo,
	output logic                    ldStStart0,
	output logic                    ldStStart1,
	output logic                    ldStWrite,
	output ExecTypesPkg::addrT      ldStAddr,
	output ExecTypesPkg::dataT      ldStData,
	output logic                    mvStart,
	input  logic                    mauValid,
	input  ExecTypesPkg::regIdxT    mauDst,
	input  ExecTypesPkg::issueNoT   mauIssueNo,
	input  ExecTypesPkg::dataT      mauData,
	input  logic                    ldValid0,
	input  ExecTypesPkg::regIdxT    ldDst0,
	input  ExecTypesPkg::issueNoT   ldIssueNo0,
	input  ExecTypesPkg::dataT      ldData0,
	input  logic                    ldValid1,
	input  ExecTypesPkg::regIdxT    ldDst1,
	input  ExecTypesPkg::issueNoT   ldIssueNo1,
	input  ExecTypesPkg::dataT      ldData1,
	input  logic                    mvValid,
	input  ExecTypesPkg::regIdxT    mvDst,
	input  ExecTypesPkg::issueNoT   mvIssueNo,
	input  ExecTypesPkg::dataT      mvData,
	input  logic                    mauFrozen,
	input  logic                    bankIdle0,
	input  logic                    bankIdle1,
	input  logic                    mvNearFull,
	output logic                    mauAccept,
	output logic                    ldAccept0,
	output logic                    ldAccept1,
	output logic                    mvAccept,
	output logic                    stall,
	output logic                    wbValid,
	output ExecTypesPkg::regIdxT    wbDst,
	output ExecTypesPkg::issueNoT   wbIssueNo,
	output ExecTypesPkg::dataT      wbData
);
	import ExecTypesPkg::*;
	import ExecConfigPkg::*;

	logic                    isLdSt;
	dataT                    addrSum;
	logic [NumWbSources-1:0] srcValid;
	issueNoT                 srcAge [NumWbSources];
	logic [NumWbSources-1:0] grant;
	issueNoT                 wbAge;

	//////////////////////
	// Decode
	//////////////////////
	always_comb begin
		mauStart  = 1'b0;
		mvStart   = 1'b0;
		isLdSt    = 1'b0;
		ldStWrite = 1'b0;
		mauB      = srcB;
		mauC      = srcC;
		case (op)
			OpMulAdd: mauStart = req;
			OpMul: begin
				mauStart = req;
				mauC     = '0;	// No addend
			end
			OpAdd: begin
				mauStart = req;
				mauB     = dataT'(1);	// Multiply by one
			end
			OpMove:  mvStart = req;
			OpLoad:  isLdSt  = req;
			OpStore: begin
				isLdSt    = req;
				ldStWrite = 1'b1;
			end
			default: ;	// Unused codes start nothing
		endcase
	end

	assign mauA          = srcA;
	assign mauTagDst     = dst;
	assign mauTagIssueNo = issueNo;

	assign addrSum    = srcA + srcB;
	assign ldStAddr   = addrSum[AddrWidth-1:0];	// Word address wraps at 16 bits
	assign ldStData   = srcC;
	assign ldStStart0 = isLdSt & ~ldStAddr[0];	// Even bank
	assign ldStStart1 = isLdSt &  ldStAddr[0];	// Odd bank

	// Either busy bank blocks issue, whatever the target
	assign stall = mauFrozen | ~bankIdle0 | ~bankIdle1 | mvNearFull;

	//////////////////////
	// Write-back by age
	//////////////////////
	assign srcValid  = {mvValid, ldValid1, ldValid0, mauValid};
	assign srcAge[0] = curIssueNo - mauIssueNo;
	assign srcAge[1] = curIssueNo - ldIssueNo0;
	assign srcAge[2] = curIssueNo - ldIssueNo1;
	assign srcAge[3] = curIssueNo - mvIssueNo;

	always_comb begin
		grant = '0;
		wbAge = '0;
		for (int i = 0; i < NumWbSources; i++) begin
			if (srcValid[i] && (grant == '0 || srcAge[i] > wbAge)) begin
				grant    = '0;
				grant[i] = 1'b1;
				wbAge    = srcAge[i];
			end
		end
	end

	assign mauAccept = grant[0];
	assign ldAccept0 = grant[1];
	assign ldAccept1 = grant[2];
	assign mvAccept  = grant[3];
	assign wbValid   = |srcValid;

	always_comb begin
		wbDst     = mvDst;	// Move buffer when nothing else wins
		wbIssueNo = mvIssueNo;
		wbData    = mvData;
		if (grant[0]) begin
			wbDst     = mauDst;
			wbIssueNo = mauIssueNo;
			wbData    = mauData;
		end else if (grant[1]) begin
			wbDst     = ldDst0;
			wbIssueNo = ldIssueNo0;
			wbData    = ldData0;
		end else if (grant[2]) begin
			wbDst     = ldDst1;
			wbIssueNo = ldIssueNo1;
			wbData    = ldData1;
		end
	end

	assert property (@(posedge clock) disable iff (reset) req |-> !stall)
		else $error("req issued while stall is high");
	assert property (@(posedge clock) disable iff (reset)
		$onehot0({mauAccept, ldAccept0, ldAccept1, mvAccept}))
		else $error("more than one write-back accept");
	// A pending result was issued earlier and not too long ago
	assert property (@(posedge clock) disable iff (reset)
		wbValid |-> (wbAge != '0) && (wbAge < MaxInFlight))
		else $error("write-back age out of range");

endmodule

// File: source/MulAddUnit.sv
module MulAddUnit (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    start,
	input  ExecTypesPkg::dataT      a,
	input  ExecTypesPkg::dataT      b,
	input  ExecTypesPkg::dataT      c,
	input  ExecTypesPkg::regIdxT    tagDst,
	input  ExecTypesPkg::issueNoT   tagIssueNo,
	input  logic                    accept,
	output logic                    valid,
	output ExecTypesPkg::regIdxT    dst,
	output ExecTypesPkg::issueNoT   issueNo,
	output ExecTypesPkg::dataT      result,
	output logic                    frozen
);
	import ExecTypesPkg::*;
	import ExecConfigPkg::*;

	logic    stageValid   [MulAddDepth];
	regIdxT  stageDst     [MulAddDepth];
	issueNoT stageIssueNo [MulAddDepth];
	dataT    stageData    [MulAddDepth];
	dataT    addend;	// c waits beside the product

	// Unaccepted result holds every stage
	assign frozen = stageValid[MulAddDepth-1] & ~accept;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < MulAddDepth; i++) begin
				stageValid[i] <= 1'b0;
			end
		end else if (!frozen) begin
			stageValid[0] <= start;
			for (int i = 1; i < MulAddDepth; i++) begin
				stageValid[i] <= stageValid[i-1];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!frozen) begin
			stageData[0]    <= a * b;	// Stage 1 product, wraps to 32 bits
			addend          <= c;
			stageDst[0]     <= tagDst;
			stageIssueNo[0] <= tagIssueNo;
			stageData[1]    <= stageData[0] + addend;	// Stage 2 sum
			for (int i = 2; i < MulAddDepth; i++) begin
				stageData[i] <= stageData[i-1];
			end
			for (int i = 1; i < MulAddDepth; i++) begin
				stageDst[i]     <= stageDst[i-1];
				stageIssueNo[i] <= stageIssueNo[i-1];
			end
		end
	end

	assign valid   = stageValid[MulAddDepth-1];
	assign dst     = stageDst[MulAddDepth-1];
	assign issueNo = stageIssueNo[MulAddDepth-1];
	assign result  = stageData[MulAddDepth-1];

endmodule

// File: source/LoadStoreUnit.sv
module LoadStoreUnit (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    start,
	input  logic                    write,
	input  ExecTypesPkg::addrT      addr,
	input  ExecTypesPkg::dataT      wrData,
	input  ExecTypesPkg::regIdxT    tagDst,
	input  ExecTypesPkg::issueNoT   tagIssueNo,
	output logic                    memReq,
	output logic                    memWrite,
	output ExecTypesPkg::addrT      memAddr,
	output ExecTypesPkg::dataT      stData,
	input  logic                    memGrant,
	input  logic                    memDone,
	input  ExecTypesPkg::dataT      ldData,
	input  logic                    accept,
	output logic                    valid,
	output ExecTypesPkg::regIdxT    dst,
	output ExecTypesPkg::issueNoT   issueNo,
	output ExecTypesPkg::dataT      result,
	output logic                    stDone,
	output logic                    idle
);
	import ExecTypesPkg::*;

	typedef enum logic [1:0] {
		Idle,
		Request,	// memReq up until grant
		Access,	// Granted, waiting for done
		Hold	// Load result waits for write-back
	} stateT;

	stateT   state;
	logic    writeQ;
	addrT    addrQ;
	dataT    dataQ;	// Store data, then the loaded word
	regIdxT  dstQ;
	issueNoT issueNoQ;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= Idle;
		end else begin
			case (state)
				Idle:    if (start) state <= Request;
				Request: if (memGrant) state <= Access;
				Access:  if (memDone) state <= writeQ ? Idle : Hold;
				Hold:    if (accept) state <= Idle;
				default: state <= Idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (start && state == Idle) begin
			writeQ   <= write;
			addrQ    <= addr;
			dataQ    <= wrData;
			dstQ     <= tagDst;
			issueNoQ <= tagIssueNo;
		end else if (state == Access && memDone && !writeQ) begin
			dataQ <= ldData;	// Sample on done
		end
	end

	assign memReq   = (state == Request);
	assign memWrite = writeQ & (state == Request || state == Access);
	assign memAddr  = addrQ;
	assign stData   = dataQ;
	assign stDone   = (state == Access) & writeQ & memDone;

	assign valid   = (state == Hold);
	assign dst     = dstQ;
	assign issueNo = issueNoQ;
	assign result  = dataQ;
	assign idle    = (state == Idle);

	// Control only starts a bank that reports idle
	assert property (@(posedge clock) disable iff (reset) start |-> state == Idle)
		else $error("load/store start while busy");

endmodule

// File: source/MoveBuffer.sv
module MoveBuffer (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    push,
	input  ExecTypesPkg::dataT      pushData,
	input  ExecTypesPkg::regIdxT    pushDst,
	input  ExecTypesPkg::issueNoT   pushIssueNo,
	input  logic                    pop,
	output logic                    valid,
	output ExecTypesPkg::regIdxT    dst,
	output ExecTypesPkg::issueNoT   issueNo,
	output ExecTypesPkg::dataT      data,
	output logic                    nearFull
);
	import ExecTypesPkg::*;
	import ExecConfigPkg::*;

	dataT    dataMem    [MoveDepth];
	regIdxT  dstMem     [MoveDepth];
	issueNoT issueNoMem [MoveDepth];

	logic [$clog2(MoveDepth)-1:0]   wrPtr;
	logic [$clog2(MoveDepth)-1:0]   rdPtr;
	logic [$clog2(MoveDepth+1)-1:0] count;

	always_ff @(posedge clock) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) wrPtr <= (wrPtr == MoveDepth - 1) ? '0 : wrPtr + 1'b1;
			if (pop) rdPtr <= (rdPtr == MoveDepth - 1) ? '0 : rdPtr + 1'b1;
			if (push && !pop) count <= count + 1'b1;
			else if (pop && !push) count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			dataMem[wrPtr]    <= pushData;
			dstMem[wrPtr]     <= pushDst;
			issueNoMem[wrPtr] <= pushIssueNo;
		end
	end

	assign valid    = (count != '0);
	assign dst      = dstMem[rdPtr];	// Head shows the cycle after push
	assign issueNo  = issueNoMem[rdPtr];
	assign data     = dataMem[rdPtr];
	assign nearFull = (count >= MoveDepth - 1);	// One slot left or none

	assert property (@(posedge clock) disable iff (reset) push |-> count != MoveDepth)
		else $error("move buffer push while full");
	assert property (@(posedge clock) disable iff (reset) pop |-> count != '0)
		else $error("move buffer pop while empty");

endmodule

// File: source/ExecUnitV.sv
module ExecUnitV (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    req,
	input  ExecTypesPkg::issueNoT   curIssueNo,
	input  ExecTypesPkg::opT        op,
	input  ExecTypesPkg::regIdxT    dst,
	input  ExecTypesPkg::issueNoT   issueNo,
	input  ExecTypesPkg::dataT      srcA,
	input  ExecTypesPkg::dataT      srcB,
	input  ExecTypesPkg::dataT      srcC,
	output logic                    memReq0,
	output logic                    memWrite0,
	output ExecTypesPkg::addrT      memAddr0,
	output ExecTypesPkg::dataT      stData0,
	input  logic                    memGrant0,
	input  logic                    memDone0,
	input  ExecTypesPkg::dataT      ldData0,
	output logic                    memReq1,
	output logic                    memWrite1,
	output ExecTypesPkg::addrT      memAddr1,
	output ExecTypesPkg::dataT      stData1,
	input  logic                    memGrant1,
	input  logic                    memDone1,
	input  ExecTypesPkg::dataT      ldData1,
	output logic                    stall,
	output logic                    wbValid,
	output ExecTypesPkg::regIdxT    wbDst,
	output ExecTypesPkg::issueNoT   wbIssueNo,
	output ExecTypesPkg::dataT      wbData,
	output logic                    stDone0,
	output logic                    stDone1
);
	import ExecTypesPkg::*;

	//////////////////////
	// Issue side
	//////////////////////
	logic    mauStart;
	dataT    mauA;
	dataT    mauB;
	dataT    mauC;
	regIdxT  mauTagDst;
	issueNoT mauTagIssueNo;
	logic    ldStStart0;
	logic    ldStStart1;
	logic    ldStWrite;
	addrT    ldStAddr;
	dataT    ldStData;
	logic    mvStart;

	//////////////////////
	// Result side
	//////////////////////
	logic    mauValid, mauAccept, mauFrozen;
	regIdxT  mauDst;
	issueNoT mauIssueNo;
	dataT    mauData;
	logic    ldValid0, ldAccept0, bankIdle0;
	regIdxT  ldDst0;
	issueNoT ldIssueNo0;
	dataT    ldResult0;
	logic    ldValid1, ldAccept1, bankIdle1;
	regIdxT  ldDst1;
	issueNoT ldIssueNo1;
	dataT    ldResult1;
	logic    mvValid, mvAccept, mvNearFull;
	regIdxT  mvDst;
	issueNoT mvIssueNo;
	dataT    mvData;

	ExecControl execControl (
		.clock(clock), .reset(reset), .req(req), .curIssueNo(curIssueNo),
		.op(op), .dst(dst), .issueNo(issueNo),
		.srcA(srcA), .srcB(srcB), .srcC(srcC),
		.mauStart(mauStart), .mauA(mauA), .mauB(mauB), .mauC(mauC),
		.mauTagDst(mauTagDst), .mauTagIssueNo(mauTagIssueNo),
		.ldStStart0(ldStStart0), .ldStStart1(ldStStart1), .ldStWrite(ldStWrite),
		.ldStAddr(ldStAddr), .ldStData(ldStData), .mvStart(mvStart),
		.mauValid(mauValid), .mauDst(mauDst), .mauIssueNo(mauIssueNo), .mauData(mauData),
		.ldValid0(ldValid0), .ldDst0(ldDst0), .ldIssueNo0(ldIssueNo0), .ldData0(ldResult0),
		.ldValid1(ldValid1), .ldDst1(ldDst1), .ldIssueNo1(ldIssueNo1), .ldData1(ldResult1),
		.mvValid(mvValid), .mvDst(mvDst), .mvIssueNo(mvIssueNo), .mvData(mvData),
		.mauFrozen(mauFrozen), .bankIdle0(bankIdle0), .bankIdle1(bankIdle1),
		.mvNearFull(mvNearFull),
		.mauAccept(mauAccept), .ldAccept0(ldAccept0), .ldAccept1(ldAccept1),
		.mvAccept(mvAccept), .stall(stall), .wbValid(wbValid), .wbDst(wbDst),
		.wbIssueNo(wbIssueNo), .wbData(wbData)
	);

	MulAddUnit mulAdd (
		.clock(clock), .reset(reset), .start(mauStart),
		.a(mauA), .b(mauB), .c(mauC),
		.tagDst(mauTagDst), .tagIssueNo(mauTagIssueNo), .accept(mauAccept),
		.valid(mauValid), .dst(mauDst), .issueNo(mauIssueNo), .result(mauData),
		.frozen(mauFrozen)
	);

	LoadStoreUnit bank0 (	// Even addresses
		.clock(clock), .reset(reset), .start(ldStStart0), .write(ldStWrite),
		.addr(ldStAddr), .wrData(ldStData), .tagDst(dst), .tagIssueNo(issueNo),
		.memReq(memReq0), .memWrite(memWrite0), .memAddr(memAddr0), .stData(stData0),
		.memGrant(memGrant0), .memDone(memDone0), .ldData(ldData0),
		.accept(ldAccept0), .valid(ldValid0), .dst(ldDst0), .issueNo(ldIssueNo0),
		.result(ldResult0), .stDone(stDone0), .idle(bankIdle0)
	);

	LoadStoreUnit bank1 (	// Odd addresses
		.clock(clock), .reset(reset), .start(ldStStart1), .write(ldStWrite),
		.addr(ldStAddr), .wrData(ldStData), .tagDst(dst), .tagIssueNo(issueNo),
		.memReq(memReq1), .memWrite(memWrite1), .memAddr(memAddr1), .stData(stData1),
		.memGrant(memGrant1), .memDone(memDone1), .ldData(ldData1),
		.accept(ldAccept1), .valid(ldValid1), .dst(ldDst1), .issueNo(ldIssueNo1),
		.result(ldResult1), .stDone(stDone1), .idle(bankIdle1)
	);

	MoveBuffer moveBuffer (
		.clock(clock), .reset(reset), .push(mvStart),
		.pushData(srcA), .pushDst(dst), .pushIssueNo(issueNo),
		.pop(mvAccept), .valid(mvValid), .dst(mvDst), .issueNo(mvIssueNo),
		.data(mvData), .nearFull(mvNearFull)
	);

endmodule

// File: testbench/ExecUnitChecker.sv
module ExecUnitChecker (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    req,
	input  ExecTypesPkg::issueNoT   curIssueNo,
	input  ExecTypesPkg::opT        op,
	input  ExecTypesPkg::regIdxT    dst,
	input  ExecTypesPkg::issueNoT   issueNo,
	input  ExecTypesPkg::dataT      srcA,
	input  ExecTypesPkg::dataT      srcB,
	input  ExecTypesPkg::dataT      srcC,
	input  logic [1:0]              memReq,
	input  logic [1:0]              memWrite,
	input  logic [1:0]              memGrant,
	input  logic [1:0]              memDone,
	input  logic [1:0]              stDone,
	input  ExecTypesPkg::addrT      memAddr0,
	input  ExecTypesPkg::addrT      memAddr1,
	input  ExecTypesPkg::dataT      stData0,
	input  ExecTypesPkg::dataT      stData1,
	input  logic                    stall,
	input  logic                    wbValid,
	input  ExecTypesPkg::regIdxT    wbDst,
	input  ExecTypesPkg::issueNoT   wbIssueNo,
	input  ExecTypesPkg::dataT      wbData,
	output int                      errorCount,
	output int                      doneCount,
	output int                      outstanding
);
	timeunit 1ns;
	timeprecision 100ps;
	import ExecTypesPkg::*;

	int      errors = 0;
	int      done = 0;
	int      open = 0;
	logic    afterReset = 1'b1;
	logic    pending [64] = '{default: 1'b0};	// Indexed by issue number
	logic    ready [64] = '{default: 1'b0};	// Eligible for write-back
	opT      kind [64];
	regIdxT  expDst [64];
	dataT    expData [64];
	dataT    cmdC [64];
	addrT    expAddr [64];
	dataT    shadow [addrT];	// Memory as the stores left it
	issueNoT bankQueue0 [$];
	issueNoT bankQueue1 [$];
	issueNoT accessNo [2];

	assign errorCount  = errors;
	assign doneCount   = done;
	assign outstanding = open;

	////////////////////
	// Reference model
	////////////////////
	function automatic dataT referenceResult(opT o, dataT a, dataT b, dataT c);
		addrT ad;
		ad = addrT'(a + b);
		case (o)
			OpMulAdd: return a * b + c;
			OpMul:    return a * b;
			OpAdd:    return a + c;	// Multiplier of one
			OpMove:   return a;
			OpLoad:   return shadow.exists(ad) ? shadow[ad] : dataT'(ad) * 3 + 7;
			default:  return '0;
		endcase
	endfunction

	function automatic issueNoT ageOf(issueNoT no);
		return curIssueNo - no;	// Wraps modulo 64
	endfunction

	task automatic reportValue(input string name, input dataT expected, input dataT actual);
		errors++;
		$display("[ERROR] %0t ns %s expected %h got %h", $time, name, expected, actual);
	endtask

	task automatic complete(input issueNoT no);
		pending[no] = 1'b0;
		open--;
		done++;
		$display("Command %0d %s complete", no, kind[no].name());
	endtask

	task automatic recordCommand;
		issueNoT no;
		no = issueNo;
		kind[no]    = op;
		expDst[no]  = dst;
		cmdC[no]    = srcC;
		expAddr[no] = addrT'(srcA + srcB);
		expData[no] = referenceResult(op, srcA, srcB, srcC);
		ready[no]   = (op == OpMove);	// Head of buffer next cycle
		pending[no] = 1'b1;
		open++;
		if (op == OpStore) shadow[expAddr[no]] = srcC;
		if (op == OpLoad || op == OpStore) begin
			if (expAddr[no][0]) bankQueue1.push_back(no);
			else bankQueue0.push_back(no);
		end
	endtask

	task automatic checkWriteBack;
		issueNoT no;
		logic    isMau;
		no = wbIssueNo;
		if (!pending[no] || kind[no] == OpStore) begin
			errors++;
			$display("Write-back at %0t ns for issue number %0d, which expects none", $time, no);
			return;
		end
		isMau = kind[no] inside {OpMulAdd, OpMul, OpAdd};
		if (wbData !== expData[no]) reportValue("wbData", expData[no], wbData);
		if (wbDst !== expDst[no]) reportValue("wbDst", dataT'(expDst[no]), dataT'(wbDst));
		for (int j = 0; j < 64; j++) begin
			if (pending[j] && j != int'(no) && kind[j] != OpStore
					&& (ready[j] || (isMau && kind[j] inside {OpMulAdd, OpMul, OpAdd}))
					&& ageOf(issueNoT'(j)) > ageOf(no)) begin
				errors++;
				$display("Write-back of issue %0d at %0t ns passed older issue %0d", no, $time, j);
			end
		end
		complete(no);
	endtask

	task automatic checkAccess(input int b);
		issueNoT no;
		addrT    addr;
		dataT    data;
		addr = b ? memAddr1 : memAddr0;
		data = b ? stData1 : stData0;
		if ((b == 0 && bankQueue0.size() == 0) || (b == 1 && bankQueue1.size() == 0)) begin
			errors++;
			$display("Bank %0d request at %0t ns with no command routed to it", b, $time);
			return;
		end
		if (b == 0) no = bankQueue0.pop_front();
		else no = bankQueue1.pop_front();
		accessNo[b] = no;
		if (addr !== expAddr[no]) begin
			reportValue($sformatf("memAddr%0d", b), dataT'(expAddr[no]), dataT'(addr));
		end
		if (memWrite[b] !== (kind[no] == OpStore)) begin
			reportValue($sformatf("memWrite%0d", b), dataT'(kind[no] == OpStore),
				dataT'(memWrite[b]));
		end
		if (kind[no] == OpStore && data !== cmdC[no]) begin
			reportValue($sformatf("stData%0d", b), cmdC[no], data);
		end
	endtask

	task automatic checkQuiet;
		if (stall !== 1'b0) reportValue("stall", '0, dataT'(stall));
		if (wbValid !== 1'b0) reportValue("wbValid", '0, dataT'(wbValid));
		if (memReq !== 2'b00) reportValue("memReq", '0, dataT'(memReq));
	endtask

	////////////////////
	// Compare each cycle
	////////////////////
	always @(negedge clock) begin	// Outputs settled mid-cycle
		if (reset) begin
			checkQuiet();
			afterReset = 1'b1;
		end else begin
			if (afterReset) checkQuiet();
			afterReset = 1'b0;
			if (wbValid) checkWriteBack();
			for (int b = 0; b < 2; b++) begin
				if (memReq[b] && memGrant[b]) checkAccess(b);
				if (memDone[b] && !memWrite[b]) ready[accessNo[b]] = 1'b1;	// Load held next
				if (stDone[b]) begin
					if (pending[accessNo[b]] && kind[accessNo[b]] == OpStore) begin
						complete(accessNo[b]);
					end else begin
						errors++;
						$display("stDone%0d at %0t ns without a store in progress", b, $time);
					end
				end
			end
			if (req) recordCommand();
		end
	end

endmodule

// File: testbench/ExecUnitTb.sv
module ExecUnitTb;
	timeunit 1ns;
	timeprecision 100ps;
	import ExecTypesPkg::*;

	localparam int NumCmds      = 120;
	localparam int CyclesPerCmd = 40;
	localparam int ClockPeriod  = 4;

	logic       clock;
	logic       reset;
	logic       req;
	issueNoT    curIssueNo;
	opT         op;
	regIdxT     dst;
	issueNoT    issueNo;
	dataT       srcA;
	dataT       srcB;
	dataT       srcC;
	logic [1:0] memReq;
	logic [1:0] memWrite;
	logic [1:0] stDone;
	addrT       memAddr0;
	addrT       memAddr1;
	dataT       stData0;
	dataT       stData1;
	logic       stall;
	logic       wbValid;
	regIdxT     wbDst;
	issueNoT    wbIssueNo;
	dataT       wbData;
	int         errorCount;
	int         doneCount;
	int         outstanding;

	int         seed = 32'h0301_1135;
	dataT       memory [addrT];
	int         phase [2];
	int         count [2];
	int         delayPick [2];
	logic [1:0] reqSeen;
	logic [1:0] writeSeen;
	addrT       addrSeen [2];
	dataT       dataSeen [2];
	logic [1:0] grantQ = '0;
	logic [1:0] doneQ = '0;
	dataT       ldWord [2] = '{default: '0};
	logic       mauCmd [64];
	int         mauPending = 0;
	int         issued;
	issueNoT    nextNo;
	logic       stallSeen;
	logic       wbSeen;
	int         pendingSeen;

	always #(ClockPeriod / 2) clock = ~clock;

	ExecUnitV dut0 (
		.clock(clock), .reset(reset), .req(req), .curIssueNo(curIssueNo),
		.op(op), .dst(dst), .issueNo(issueNo), .srcA(srcA), .srcB(srcB), .srcC(srcC),
		.memReq0(memReq[0]), .memWrite0(memWrite[0]), .memAddr0(memAddr0), .stData0(stData0),
		.memGrant0(grantQ[0]), .memDone0(doneQ[0]), .ldData0(ldWord[0]),
		.memReq1(memReq[1]), .memWrite1(memWrite[1]), .memAddr1(memAddr1), .stData1(stData1),
		.memGrant1(grantQ[1]), .memDone1(doneQ[1]), .ldData1(ldWord[1]),
		.stall(stall), .wbValid(wbValid), .wbDst(wbDst), .wbIssueNo(wbIssueNo),
		.wbData(wbData), .stDone0(stDone[0]), .stDone1(stDone[1])
	);

	ExecUnitChecker scoreboard (
		.clock(clock), .reset(reset), .req(req), .curIssueNo(curIssueNo),
		.op(op), .dst(dst), .issueNo(issueNo), .srcA(srcA), .srcB(srcB), .srcC(srcC),
		.memReq(memReq), .memWrite(memWrite), .memGrant(grantQ), .memDone(doneQ),
		.stDone(stDone), .memAddr0(memAddr0), .memAddr1(memAddr1),
		.stData0(stData0), .stData1(stData1), .stall(stall), .wbValid(wbValid),
		.wbDst(wbDst), .wbIssueNo(wbIssueNo), .wbData(wbData),
		.errorCount(errorCount), .doneCount(doneCount), .outstanding(outstanding)
	);

	function automatic dataT readWord(addrT a);
		return memory.exists(a) ? memory[a] : dataT'(a) * 3 + 7;	// Power-up content
	endfunction

	////////////////////
	// Memory banks
	////////////////////
	always @(negedge clock) begin	// Capture settled DUT outputs
		for (int b = 0; b < 2; b++) begin
			delayPick[b] = $unsigned($random(seed)) % 4;
		end
		reqSeen     = memReq;
		writeSeen   = memWrite;
		addrSeen[0] = memAddr0;
		addrSeen[1] = memAddr1;
		dataSeen[0] = stData0;
		dataSeen[1] = stData1;
		if (reset) mauPending <= 0;
		else mauPending <= mauPending + ((req && op inside {OpMulAdd, OpMul, OpAdd}) ? 1 : 0)
			- ((wbValid && mauCmd[wbIssueNo]) ? 1 : 0);
		if (req) mauCmd[issueNo] = op inside {OpMulAdd, OpMul, OpAdd};
	end

	always @(posedge clock) begin
		for (int b = 0; b < 2; b++) begin
			if (reset) begin
				phase[b]  <= 0;
				grantQ[b] <= 1'b0;
				doneQ[b]  <= 1'b0;
			end else begin
				case (phase[b])
					0: if (reqSeen[b]) begin
						count[b] <= delayPick[b];	// Grant wait
						phase[b] <= 1;
					end
					1: if (count[b] == 0) begin
						grantQ[b] <= 1'b1;
						phase[b]  <= 2;
					end else count[b] <= count[b] - 1;
					2: begin
						grantQ[b] <= 1'b0;
						count[b]  <= delayPick[b];	// Done wait
						phase[b]  <= 3;
					end
					3: if (count[b] == 0) begin
						doneQ[b] <= 1'b1;
						if (writeSeen[b]) memory[addrSeen[b]] = dataSeen[b];
						else ldWord[b] <= readWord(addrSeen[b]);
						phase[b] <= 4;
					end else count[b] <= count[b] - 1;
					default: begin
						doneQ[b] <= 1'b0;
						phase[b] <= 0;
					end
				endcase
			end
		end
	end

	////////////////////
	// Stimulus
	////////////////////
	task automatic driveCommand;
		opT   pick;
		dataT a;
		dataT b;
		if (issued % 16 < 5) pick = OpMove;	// Move bursts
		else pick = opT'(3'($unsigned($random(seed)) % 6));
		a = $random(seed);
		b = $random(seed);
		if (pick == OpLoad || pick == OpStore) begin
			a = a & 32'h7;	// Few addresses so loads meet stores
			b = b & 32'h7;
		end
		req        <= 1'b1;
		op         <= pick;
		dst        <= regIdxT'($random(seed));
		issueNo    <= nextNo;
		curIssueNo <= nextNo;
		srcA       <= a;
		srcB       <= b;
		srcC       <= $random(seed);
		nextNo = nextNo + 1'b1;
		issued++;
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		req = 1'b0;
		curIssueNo = '0;
		op = OpMove;
		dst = '0;
		issueNo = '0;
		srcA = '0;
		srcB = '0;
		srcC = '0;
		issued = 0;
		nextNo = '0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		while (issued < NumCmds) begin
			@(negedge clock);
			stallSeen   = stall;
			wbSeen      = wbValid;
			pendingSeen = mauPending;
			@(posedge clock);
			if (req) begin
				req        <= 1'b0;
				curIssueNo <= nextNo;
			end else if (!stallSeen && (pendingSeen == 0 || !wbSeen)
					&& $unsigned($random(seed)) % 4 != 0) begin	// Idle gaps let results collide
				driveCommand();	// No MAU result can freeze next cycle
			end
		end
		@(posedge clock);
		req        <= 1'b0;
		curIssueNo <= nextNo;
		while (outstanding != 0) @(posedge clock);
		repeat (2) @(posedge clock);
		$display("Issued %0d, completed %0d, errors %0d", issued, doneCount, errorCount);
		if (errorCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin	// Watchdog
		#(NumCmds * CyclesPerCmd * ClockPeriod);
		$display("Timeout with %0d commands still outstanding", outstanding);
		$display("Errors found");
		$finish;
	end

endmodule

// File: filelist.f
source/ExecTypesPkg.sv
source/ExecConfigPkg.sv
source/ExecControl.sv
source/MulAddUnit.sv
source/LoadStoreUnit.sv
source/MoveBuffer.sv
source/ExecUnitV.sv
testbench/ExecUnitChecker.sv
testbench/ExecUnitTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the execution lane testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module ExecUnitTb \
	-f filelist.f -o simv
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "No errors" "$LOG"; then
	exit 0
fi
exit 1
